// ==== all.f ====
+incdir+.
sniff_pkg.sv
reg_bus_if.sv
sniff_regs.sv
capture_packer.sv
sniff_fifo.sv
sniff_readout.sv
sniff_reg_top.sv
tb_sniff_reg.sv

// ==== tb_sniff_reg.sv ====
`timescale 1ns/1ps
`include "sniff_defines.svh"

module tb_sniff_reg;
   import sniff_pkg::*;

   // Whole test run takes roughly a thousand cycles
   localparam int CYCLE_LIMIT = 20000;

   logic                              cwusb_clk;
   logic                              reset_i;
   logic [`SNIFF_ADDR_W-1:0]          reg_address;
   logic [`SNIFF_BYTECNT_W-1:0]       reg_bytecnt;
   logic                              reg_read;
   logic                              reg_write;
   logic                              reg_addrvalid;
   logic [7:0]                        write_data;
   logic [7:0]                        read_data;
   logic                              fe_capture_data_wr;
   fe_cmd_e                           fe_capture_cmd;
   logic [`SNIFF_TIME_W-1:0]          fe_capture_time;
   logic [7:0]                        fe_capture_data;
   logic [`SNIFF_STAT_W-1:0]          fe_capture_stat;
   logic                              match;
   logic                              arm_out;
   logic                              fifo_full;
   logic                              timestamps_disable;
   logic [8*`SNIFF_PATTERN_BYTES-1:0] pattern;
   logic [8*`SNIFF_PATTERN_BYTES-1:0] pattern_mask;
   logic [1:0]                        pattern_action;
   logic [7:0]                        pattern_bytes;
   logic [`SNIFF_CAPLEN_W-1:0]        capture_len;
   logic [`SNIFF_TRIG_DELAY_W-1:0]    trigger_delay;
   logic [`SNIFF_TRIG_WIDTH_W-1:0]    trigger_width;

   string       test_name;
   integer      seed;
   int          cycles = 0;
   fifo_entry_t sent_q[$];

   sniff_reg_top sniff_reg_top_i (.*);

   initial cwusb_clk = 1'b0;
   always #5 cwusb_clk = ~cwusb_clk;

   always @(posedge cwusb_clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
         fail_run("Timeout: the cycle limit was reached before the tests finished");
   end

   //////////////////////////////
   // Reporting and compares
   //////////////////////////////
   task automatic fail_run(input string what);
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
         fail_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                            test_name, what, exp, act));
   endtask

   task automatic check_entry(input string what, input fifo_entry_t exp, input fifo_entry_t act);
      if (act !== exp)
         fail_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                            test_name, what, exp, act));
   endtask

   task automatic check_status(input string what, input fifo_status_t exp,
                               input fifo_status_t act);
      if (act !== exp)
         fail_run($sformatf("CHECK FAILED %s %s: expected %b, actual %b",
                            test_name, what, exp, act));
   endtask

   task automatic check_cmd(input string what, input fe_cmd_e exp, input fe_cmd_e act);
      if (act !== exp)
         fail_run($sformatf("CHECK FAILED %s %s: expected %s, actual %s",
                            test_name, what, exp.name(), act.name()));
   endtask

   // Layout: status 17..13, data 12..5, short time 4..2, command 1..0
   function automatic fifo_entry_t expected_entry(input fe_cmd_e cmd, input logic [15:0] t,
                                                  input logic [7:0] d, input logic [4:0] s);
      case (cmd)
         CMD_DATA: return {s, d, t[2:0], cmd};
         CMD_STAT: return {s, 8'h00, t[2:0], cmd};
         CMD_TIME: return {t, cmd};
         default:  return {16'h0000, cmd};
      endcase
   endfunction

   function automatic fifo_entry_t marker_entry();
      return {5'b00000, `SNIFF_EMPTY_MARKER, 3'b000, CMD_STRM};
   endfunction

   //////////////////////////////
   // Bus and capture drivers
   //////////////////////////////
   task automatic bus_write(input reg_addr_e addr, input int bc, input logic [7:0] data);
      @(posedge cwusb_clk);
      reg_address   <= addr;
      reg_bytecnt   <= `SNIFF_BYTECNT_W'(bc);
      write_data    <= data;
      reg_write     <= 1'b1;
      reg_addrvalid <= 1'b1;
      @(posedge cwusb_clk);
      reg_write     <= 1'b0;
      reg_addrvalid <= 1'b0;
   endtask

   task automatic bus_read_reg(input reg_addr_e addr, input int bc, output logic [7:0] data);
      @(posedge cwusb_clk);
      reg_address   <= addr;
      reg_bytecnt   <= `SNIFF_BYTECNT_W'(bc);
      reg_read      <= 1'b1;
      reg_addrvalid <= 1'b1;
      @(posedge cwusb_clk);
      reg_read      <= 1'b0;
      reg_addrvalid <= 1'b0;
      // Registered readback lands one cycle after the strobe
      @(negedge cwusb_clk);
      data = read_data;
   endtask

   task automatic bus_read_entry(output fifo_entry_t e, output fifo_status_t st);
      logic [7:0] b0;
      logic [7:0] b1;
      logic [7:0] b2;
      @(posedge cwusb_clk);
      reg_address   <= REG_SNIFF_FIFO_RD;
      reg_bytecnt   <= '0;
      reg_read      <= 1'b1;
      reg_addrvalid <= 1'b1;
      @(negedge cwusb_clk);
      b0 = read_data;
      @(posedge cwusb_clk);
      reg_bytecnt <= `SNIFF_BYTECNT_W'(1);
      @(negedge cwusb_clk);
      b1 = read_data;
      @(posedge cwusb_clk);
      reg_bytecnt <= `SNIFF_BYTECNT_W'(2);
      @(negedge cwusb_clk);
      b2 = read_data;
      @(posedge cwusb_clk);
      reg_read      <= 1'b0;
      reg_addrvalid <= 1'b0;
      e  = {b2[1:0], b1, b0};
      st = fifo_status_t'(b2[6:2]);
   endtask

   task automatic capture_event(input fe_cmd_e cmd, input logic [15:0] t,
                                input logic [7:0] d, input logic [4:0] s);
      @(posedge cwusb_clk);
      fe_capture_data_wr <= 1'b1;
      fe_capture_cmd     <= cmd;
      fe_capture_time    <= t;
      fe_capture_data    <= d;
      fe_capture_stat    <= s;
   endtask

   task automatic capture_stop();
      @(posedge cwusb_clk);
      fe_capture_data_wr <= 1'b0;
   endtask

   task automatic send_random(input fe_cmd_e cmd);
      logic [15:0] t;
      logic [7:0]  d;
      logic [4:0]  s;
      t = $random(seed);
      d = $random(seed);
      s = $random(seed);
      capture_event(cmd, t, d, s);
      sent_q.push_back(expected_entry(cmd, t, d, s));
   endtask

   // Reads until the marker shows up, checking order against what was sent
   task automatic drain_and_compare(output int n, output fifo_status_t st);
      fifo_entry_t e;
      fifo_entry_t exp;
      n = 0;
      bus_read_entry(e, st);
      while (fe_cmd_e'(e[1:0]) != CMD_STRM) begin
         if (sent_q.size() == 0) begin
            fail_run("Readout returned more entries than were captured");
         end else begin
            exp = sent_q.pop_front();
            check_cmd($sformatf("entry %0d command", n), fe_cmd_e'(exp[1:0]),
                      fe_cmd_e'(e[1:0]));
            check_entry($sformatf("entry %0d", n), exp, e);
            n++;
            bus_read_entry(e, st);
         end
      end
      check_entry("empty marker after drain", marker_entry(), e);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////
   task automatic config_test();
      logic [63:0] pat;
      logic [63:0] msk;
      logic [7:0]  b;
      test_name = "config";
      pat = 64'h0123_4567_89ab_cdef;
      msk = 64'hff00_f0f0_0f0f_00ff;
      for (int i = 0; i < `SNIFF_PATTERN_BYTES; i++) begin
         bus_write(REG_PATTERN, i, pat[i*8 +: 8]);
         bus_write(REG_PATTERN_MASK, i, msk[i*8 +: 8]);
      end
      bus_write(REG_PATTERN_ACTION, 0, 8'ha6);
      bus_write(REG_PATTERN_BYTES, 0, 8'h05);
      bus_write(REG_TIMESTAMPS_DISABLE, 0, 8'h01);
      bus_write(REG_CAPTURE_LEN, 0, 8'h34);
      bus_write(REG_CAPTURE_LEN, 1, 8'h12);
      bus_write(REG_TRIGGER_DELAY, 0, 8'h56);
      bus_write(REG_TRIGGER_DELAY, 1, 8'h34);
      // Upper nibble of this byte is past bit 19
      bus_write(REG_TRIGGER_DELAY, 2, 8'hfa);
      bus_write(REG_TRIGGER_WIDTH, 0, 8'hef);
      bus_write(REG_TRIGGER_WIDTH, 1, 8'hbe);
      @(negedge cwusb_clk);
      for (int i = 0; i < `SNIFF_PATTERN_BYTES; i++) begin
         check_byte($sformatf("pattern port byte %0d", i), pat[i*8 +: 8], pattern[i*8 +: 8]);
         check_byte($sformatf("mask port byte %0d", i), msk[i*8 +: 8], pattern_mask[i*8 +: 8]);
      end
      check_byte("pattern_action port", 8'h02, {6'b0, pattern_action});
      check_byte("pattern_bytes port", 8'h05, pattern_bytes);
      check_byte("timestamps_disable port", 8'h01, {7'b0, timestamps_disable});
      check_byte("capture_len low", 8'h34, capture_len[7:0]);
      check_byte("capture_len high", 8'h12, capture_len[15:8]);
      check_byte("trigger_delay byte 0", 8'h56, trigger_delay[7:0]);
      check_byte("trigger_delay byte 1", 8'h34, trigger_delay[15:8]);
      check_byte("trigger_delay byte 2", 8'h0a, {4'h0, trigger_delay[19:16]});
      check_byte("trigger_width low", 8'hef, trigger_width[7:0]);
      check_byte("trigger_width high", 8'hbe, trigger_width[15:8]);
      for (int i = 0; i < `SNIFF_PATTERN_BYTES; i++) begin
         bus_read_reg(REG_PATTERN, i, b);
         check_byte($sformatf("pattern readback %0d", i), pat[i*8 +: 8], b);
         bus_read_reg(REG_PATTERN_MASK, i, b);
         check_byte($sformatf("mask readback %0d", i), msk[i*8 +: 8], b);
      end
      bus_read_reg(REG_PATTERN_ACTION, 0, b);
      check_byte("pattern_action readback", 8'h02, b);
      bus_read_reg(REG_PATTERN_BYTES, 0, b);
      check_byte("pattern_bytes readback", 8'h05, b);
      // Write-only register reads as zero
      bus_read_reg(REG_CAPTURE_LEN, 0, b);
      check_byte("capture_len readback", 8'h00, b);
   endtask

   task automatic packing_test();
      int           n;
      fifo_status_t st;
      logic [7:0]   b;
      test_name = "packing";
      sent_q.delete();
      send_random(CMD_DATA);
      send_random(CMD_STAT);
      send_random(CMD_TIME);
      capture_stop();
      drain_and_compare(n, st);
      if (n != 3)
         fail_run($sformatf("Packing test read back %0d entries instead of 3", n));
      bus_read_reg(REG_SNIFF_FIFO_STAT, 0, b);
      // Bits: full_threshold, overflow_blocked, full, empty_threshold, empty
      check_status("status after drain", fifo_status_t'(5'b00001), fifo_status_t'(b[4:0]));
   endtask

   task automatic empty_marker_test();
      fifo_entry_t  e;
      fifo_status_t st;
      test_name = "empty_marker";
      bus_read_entry(e, st);
      check_cmd("marker command", CMD_STRM, fe_cmd_e'(e[1:0]));
      check_byte("marker data", `SNIFF_EMPTY_MARKER, e[12:5]);
      check_entry("marker entry", marker_entry(), e);
      check_status("status beside marker", fifo_status_t'(5'b00001), st);
   endtask

   task automatic overflow_test();
      int           n;
      fifo_status_t st;
      logic [7:0]   b;
      test_name = "overflow";
      sent_q.delete();
      for (int i = 0; i < 40; i++)
         send_random(fe_cmd_e'(2'(i % 3)));
      capture_stop();
      bus_read_reg(REG_SNIFF_FIFO_STAT, 0, b);
      check_status("status after burst", fifo_status_t'(5'b11000), fifo_status_t'(b[4:0]));
      // Threshold headroom keeps the FIFO short of full
      check_byte("fifo_full port after burst", 8'h00, {7'b0, fifo_full});
      drain_and_compare(n, st);
      if (n < `SNIFF_FULL_THRESH || n > `SNIFF_FIFO_DEPTH)
         fail_run($sformatf("Overflow test kept %0d entries, outside the allowed range", n));
      check_status("status at marker", fifo_status_t'(5'b01001), st);
      sent_q.delete();
   endtask

   task automatic arm_flush_test();
      logic [7:0] b;
      test_name = "arm_flush";
      for (int i = 0; i < 5; i++)
         send_random(CMD_DATA);
      capture_stop();
      sent_q.delete();
      bus_write(REG_ARM, 0, 8'h01);
      @(posedge cwusb_clk);
      @(negedge cwusb_clk);
      check_byte("arm_out held during flush", 8'h00, {7'b0, arm_out});
      do
         @(negedge cwusb_clk);
      while (arm_out !== 1'b1);
      bus_read_reg(REG_SNIFF_FIFO_STAT, 0, b);
      check_status("status after flush", fifo_status_t'(5'b00001), fifo_status_t'(b[4:0]));
      bus_read_reg(REG_ARM, 0, b);
      check_byte("arm readback while armed", 8'h01, b);
      @(posedge cwusb_clk);
      match <= 1'b1;
      @(posedge cwusb_clk);
      match <= 1'b0;
      @(posedge cwusb_clk);
      @(negedge cwusb_clk);
      check_byte("arm_out after match", 8'h00, {7'b0, arm_out});
      bus_read_reg(REG_ARM, 0, b);
      check_byte("arm readback after match", 8'h00, b);
   endtask

   initial begin
      seed               = 88;
      reset_i            = 1'b1;
      reg_address        = '0;
      reg_bytecnt        = '0;
      reg_read           = 1'b0;
      reg_write          = 1'b0;
      reg_addrvalid      = 1'b0;
      write_data         = 8'h00;
      fe_capture_data_wr = 1'b0;
      fe_capture_cmd     = CMD_DATA;
      fe_capture_time    = '0;
      fe_capture_data    = 8'h00;
      fe_capture_stat    = '0;
      match              = 1'b0;
      repeat (4) @(posedge cwusb_clk);
      reset_i <= 1'b0;
      config_test();
      packing_test();
      empty_marker_test();
      overflow_test();
      arm_flush_test();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== sniff_reg_top.sv ====
`timescale 1ns/1ps
`include "sniff_defines.svh"

module sniff_reg_top (
   input  logic                              cwusb_clk,
   input  logic                              reset_i,
   input  logic [`SNIFF_ADDR_W-1:0]          reg_address,
   input  logic [`SNIFF_BYTECNT_W-1:0]       reg_bytecnt,
   input  logic                              reg_read,
   input  logic                              reg_write,
   input  logic                              reg_addrvalid,
   input  logic [7:0]                        write_data,
   output logic [7:0]                        read_data,
   input  logic                              fe_capture_data_wr,
   input  sniff_pkg::fe_cmd_e                fe_capture_cmd,
   input  logic [`SNIFF_TIME_W-1:0]          fe_capture_time,
   input  logic [7:0]                        fe_capture_data,
   input  logic [`SNIFF_STAT_W-1:0]          fe_capture_stat,
   input  logic                              match,
   output logic                              arm_out,
   output logic                              fifo_full,
   output logic                              timestamps_disable,
   output logic [8*`SNIFF_PATTERN_BYTES-1:0] pattern,
   output logic [8*`SNIFF_PATTERN_BYTES-1:0] pattern_mask,
   output logic [1:0]                        pattern_action,
   output logic [7:0]                        pattern_bytes,
   output logic [`SNIFF_CAPLEN_W-1:0]        capture_len,
   output logic [`SNIFF_TRIG_DELAY_W-1:0]    trigger_delay,
   output logic [`SNIFF_TRIG_WIDTH_W-1:0]    trigger_width
);
   import sniff_pkg::*;

   logic         armed;
   logic [7:0]   reg_rdata;
   fifo_status_t fifo_status;
   logic         wr_en;
   logic         rd_en;
   fifo_entry_t  entry;
   fifo_entry_t  head;
   logic         empty;
   logic         prog_full;
   logic         empty_threshold;
   logic         overflow_blocked;

   // Host bus into the shared interface
   reg_bus_if bus ();

   assign bus.addr       = reg_address;
   assign bus.bytecnt    = reg_bytecnt;
   assign bus.read       = reg_read;
   assign bus.write      = reg_write;
   assign bus.addrvalid  = reg_addrvalid;
   assign bus.write_data = write_data;

   sniff_regs sniff_regs_i (
      .cwusb_clk, .reset_i, .bus, .match, .fifo_status, .armed, .reg_rdata,
      .timestamps_disable, .pattern, .pattern_mask, .pattern_action, .pattern_bytes,
      .capture_len, .trigger_delay, .trigger_width
   );

   capture_packer capture_packer_i (
      .cwusb_clk, .reset_i,
      .capture_wr   (fe_capture_data_wr),
      .capture_cmd  (fe_capture_cmd),
      .capture_time (fe_capture_time),
      .capture_data (fe_capture_data),
      .capture_stat (fe_capture_stat),
      .prog_full, .armed, .wr_en, .entry, .overflow_blocked
   );

   sniff_fifo sniff_fifo_i (
      .cwusb_clk, .reset_i, .wr_en, .din (entry), .rd_en, .dout (head),
      .empty, .full (fifo_full), .prog_full, .empty_threshold
   );

   sniff_readout sniff_readout_i (
      .cwusb_clk, .reset_i, .bus, .armed, .reg_rdata, .head, .empty,
      .full (fifo_full), .prog_full, .empty_threshold, .overflow_blocked,
      .rd_en, .arm_out, .fifo_status, .read_data
   );

endmodule

// ==== sniff_readout.sv ====
`timescale 1ns/1ps
`include "sniff_defines.svh"

module sniff_readout (
   input  logic                     cwusb_clk,
   input  logic                     reset_i,
   reg_bus_if.listener              bus,
   input  logic                     armed,
   input  logic [7:0]               reg_rdata,
   input  sniff_pkg::fifo_entry_t   head,
   input  logic                     empty,
   input  logic                     full,
   input  logic                     prog_full,
   input  logic                     empty_threshold,
   input  logic                     overflow_blocked,
   output logic                     rd_en,
   output logic                     arm_out,
   output sniff_pkg::fifo_status_t  fifo_status,
   output logic [7:0]               read_data
);
   import sniff_pkg::*;

   fifo_entry_t marker;
   fifo_entry_t live;
   fifo_entry_t held;
   logic        fifo_sel;
   logic        rd_byte0;
   logic        arm_q;
   logic        flushing;

   assign fifo_sel = bus.addrvalid && (bus.addr == REG_SNIFF_FIFO_RD);
   assign rd_byte0 = fifo_sel && bus.read && (bus.bytecnt[1:0] == 2'd0);

   // Host pop or flush pop, never both needed in one cycle
   assign rd_en = !empty && (rd_byte0 || flushing);

   always_comb begin
      marker = '0;
      marker[`SNIFF_CMD_START +: `SNIFF_CMD_W]   = CMD_STRM;
      marker[`SNIFF_DATA_START +: `SNIFF_DATA_W] = `SNIFF_EMPTY_MARKER;
      live = empty ? marker : head;
   end

   // Bytes 1 and 2 come from the entry latched on byte 0
   always_ff @(posedge cwusb_clk) begin
      if (rd_byte0)
         held <= live;
   end

   //////////////////////////////
   // Flush on arm
   //////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         arm_q    <= 1'b0;
         flushing <= 1'b0;
      end else begin
         arm_q <= armed;
         if (empty)
            flushing <= 1'b0;
         else if (armed && !arm_q)
            flushing <= 1'b1;
      end
   end

   assign arm_out = arm_q && !flushing;

   // Threshold flag only means something below full
   assign fifo_status.full_threshold   = prog_full && !full;
   assign fifo_status.overflow_blocked = overflow_blocked;
   assign fifo_status.full             = full;
   assign fifo_status.empty_threshold  = empty_threshold;
   assign fifo_status.empty            = empty;

   //////////////////////////////
   // Read data mux
   //////////////////////////////
   always_comb begin
      if (fifo_sel) begin
         case (bus.bytecnt[1:0])
            2'd0:    read_data = live[7:0];
            2'd1:    read_data = held[15:8];
            2'd2:    read_data = {1'b0, fifo_status, held[17:16]};
            default: read_data = 8'h00;
         endcase
      end else begin
         read_data = reg_rdata;
      end
   end

endmodule

// ==== sniff_fifo.sv ====
`timescale 1ns/1ps
`include "sniff_defines.svh"

module sniff_fifo (
   input  logic                   cwusb_clk,
   input  logic                   reset_i,
   input  logic                   wr_en,
   input  sniff_pkg::fifo_entry_t din,
   input  logic                   rd_en,
   output sniff_pkg::fifo_entry_t dout,
   output logic                   empty,
   output logic                   full,
   output logic                   prog_full,
   output logic                   empty_threshold
);
   import sniff_pkg::*;

   localparam int AW = $clog2(`SNIFF_FIFO_DEPTH);

   fifo_entry_t   mem [`SNIFF_FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          do_wr;
   logic          do_rd;

   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   always_ff @(posedge cwusb_clk) begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

   // Pointers wrap on their own since depth is a power of two
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
      end
   end

   // Head is visible without a read latency
   assign dout = mem[rd_ptr];

   assign empty           = (count == 0);
   assign full            = (count == `SNIFF_FIFO_DEPTH);
   assign prog_full       = (count >= `SNIFF_FULL_THRESH);
   assign empty_threshold = (count <= `SNIFF_EMPTY_THRESH) && !empty;

   // Packer headroom from prog_full must keep writes off a full FIFO
   a_no_write_when_full: assert property (@(posedge cwusb_clk) disable iff (reset_i)
      wr_en |-> !full)
      else $error("capture write reached a full FIFO");

   a_no_pop_when_empty: assert property (@(posedge cwusb_clk) disable iff (reset_i)
      rd_en |-> !empty)
      else $error("readout popped an empty FIFO");

endmodule

// ==== capture_packer.sv ====
`timescale 1ns/1ps
`include "sniff_defines.svh"

module capture_packer (
   input  logic                           cwusb_clk,
   input  logic                           reset_i,
   input  logic                           capture_wr,
   input  sniff_pkg::fe_cmd_e             capture_cmd,
   input  logic [`SNIFF_TIME_W-1:0]       capture_time,
   input  logic [7:0]                     capture_data,
   input  logic [`SNIFF_STAT_W-1:0]       capture_stat,
   input  logic                           prog_full,
   input  logic                           armed,
   output logic                           wr_en,
   output sniff_pkg::fifo_entry_t         entry,
   output logic                           overflow_blocked
);
   import sniff_pkg::*;

   fifo_entry_t next_entry;
   logic        accept;

   // Back-to-back strobes can outrun full, so gate on the threshold
   assign accept = capture_wr && !prog_full;

   //////////////////////////////
   // Entry packing
   //////////////////////////////
   always_comb begin
      next_entry = '0;
      next_entry[`SNIFF_CMD_START +: `SNIFF_CMD_W] = capture_cmd;
      case (capture_cmd)
         CMD_DATA, CMD_STAT: begin
            next_entry[`SNIFF_STIME_START +: `SNIFF_SHORTTIME_W] =
               capture_time[`SNIFF_SHORTTIME_W-1:0];
            next_entry[`SNIFF_STATUS_START +: `SNIFF_STAT_W] = capture_stat;
            // Status entries carry no data byte
            if (capture_cmd == CMD_DATA)
               next_entry[`SNIFF_DATA_START +: `SNIFF_DATA_W] = capture_data;
         end
         CMD_TIME: begin
            next_entry[`SNIFF_FTIME_START +: `SNIFF_TIME_W] = capture_time;
         end
         default: ;
      endcase
   end

   always_ff @(posedge cwusb_clk) begin
      if (accept)
         entry <= next_entry;
   end

   // Write strobe and the sticky drop flag
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         wr_en            <= 1'b0;
         overflow_blocked <= 1'b0;
      end else begin
         wr_en <= accept;
         if (capture_wr && prog_full)
            overflow_blocked <= 1'b1;
         else if (armed)
            overflow_blocked <= 1'b0;
      end
   end

endmodule

// ==== sniff_regs.sv ====
`timescale 1ns/1ps
`include "sniff_defines.svh"

module sniff_regs (
   input  logic                                 cwusb_clk,
   input  logic                                 reset_i,
   reg_bus_if.listener                          bus,
   input  logic                                 match,
   input  sniff_pkg::fifo_status_t              fifo_status,
   output logic                                 armed,
   output logic [7:0]                           reg_rdata,
   output logic                                 timestamps_disable,
   output logic [8*`SNIFF_PATTERN_BYTES-1:0]    pattern,
   output logic [8*`SNIFF_PATTERN_BYTES-1:0]    pattern_mask,
   output logic [1:0]                           pattern_action,
   output logic [7:0]                           pattern_bytes,
   output logic [`SNIFF_CAPLEN_W-1:0]           capture_len,
   output logic [`SNIFF_TRIG_DELAY_W-1:0]       trigger_delay,
   output logic [`SNIFF_TRIG_WIDTH_W-1:0]       trigger_width
);
   import sniff_pkg::*;

   localparam int REG_W  = 8*`SNIFF_PATTERN_BYTES;
   localparam int BSEL_W = $clog2(`SNIFF_PATTERN_BYTES);

   logic wr_acc;
   logic rd_acc;

   // Replace one byte of a multi-byte register, bytes past the end are lost
   function automatic logic [REG_W-1:0] put_byte(input logic [REG_W-1:0] cur,
                                                 input logic [`SNIFF_BYTECNT_W-1:0] idx,
                                                 input logic [7:0] b);
      logic [REG_W-1:0] nxt;
      nxt = cur;
      if (idx < `SNIFF_PATTERN_BYTES)
         nxt[idx[BSEL_W-1:0]*8 +: 8] = b;
      return nxt;
   endfunction

   function automatic logic [7:0] get_byte(input logic [REG_W-1:0] cur,
                                           input logic [`SNIFF_BYTECNT_W-1:0] idx);
      return (idx < `SNIFF_PATTERN_BYTES) ? cur[idx[BSEL_W-1:0]*8 +: 8] : 8'h00;
   endfunction

   assign wr_acc = bus.addrvalid && bus.write;
   assign rd_acc = bus.addrvalid && bus.read;

   //////////////////////////////
   // Write side
   //////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         armed              <= 1'b0;
         timestamps_disable <= 1'b0;
         pattern            <= '0;
         pattern_mask       <= '0;
         pattern_action     <= '0;
         pattern_bytes      <= '0;
         capture_len        <= '0;
         trigger_delay      <= '0;
         trigger_width      <= '0;
      end else begin
         if (wr_acc) begin
            case (bus.addr)
               REG_TIMESTAMPS_DISABLE: timestamps_disable <= bus.write_data[0];
               REG_PATTERN:
                  pattern <= put_byte(pattern, bus.bytecnt, bus.write_data);
               REG_PATTERN_MASK:
                  pattern_mask <= put_byte(pattern_mask, bus.bytecnt, bus.write_data);
               REG_PATTERN_ACTION:
                  pattern_action <= 2'(put_byte(REG_W'(pattern_action), bus.bytecnt,
                                                bus.write_data));
               REG_PATTERN_BYTES: pattern_bytes <= bus.write_data;
               REG_CAPTURE_LEN:
                  capture_len <= `SNIFF_CAPLEN_W'(put_byte(REG_W'(capture_len),
                                                           bus.bytecnt, bus.write_data));
               // Top nibble of byte 2 falls off here
               REG_TRIGGER_DELAY:
                  trigger_delay <= `SNIFF_TRIG_DELAY_W'(put_byte(REG_W'(trigger_delay),
                                                                 bus.bytecnt, bus.write_data));
               REG_TRIGGER_WIDTH:
                  trigger_width <= `SNIFF_TRIG_WIDTH_W'(put_byte(REG_W'(trigger_width),
                                                                 bus.bytecnt, bus.write_data));
               default: ;
            endcase
         end

         // Host write wins over a match in the same cycle
         if (wr_acc && bus.addr == REG_ARM)
            armed <= bus.write_data[0];
         else if (match)
            armed <= 1'b0;
      end
   end

   //////////////////////////////
   // Registered readback
   //////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         reg_rdata <= 8'h00;
      end else if (rd_acc) begin
         case (bus.addr)
            REG_ARM:             reg_rdata <= {7'b0, armed};
            REG_PATTERN:         reg_rdata <= get_byte(pattern, bus.bytecnt);
            REG_PATTERN_MASK:    reg_rdata <= get_byte(pattern_mask, bus.bytecnt);
            REG_PATTERN_ACTION:  reg_rdata <= get_byte(REG_W'(pattern_action), bus.bytecnt);
            REG_PATTERN_BYTES:   reg_rdata <= pattern_bytes;
            REG_SNIFF_FIFO_STAT: reg_rdata <= {3'b000, fifo_status};
            default:             reg_rdata <= 8'h00;
         endcase
      end else begin
         reg_rdata <= 8'h00;
      end
   end

endmodule

// ==== reg_bus_if.sv ====
`timescale 1ns/1ps
`include "sniff_defines.svh"

interface reg_bus_if;

   logic [`SNIFF_ADDR_W-1:0]    addr;
   logic [`SNIFF_BYTECNT_W-1:0] bytecnt;
   logic                        read;
   logic                        write;
   logic                        addrvalid;
   logic [7:0]                  write_data;

   // Host side drives every field
   modport source (
      output addr,
      output bytecnt,
      output read,
      output write,
      output addrvalid,
      output write_data
   );

   // Register file and readout both only observe
   modport listener (
      input addr,
      input bytecnt,
      input read,
      input write,
      input addrvalid,
      input write_data
   );

endinterface

// ==== sniff_pkg.sv ====
`include "sniff_defines.svh"

package sniff_pkg;

   // Entry kind, bits 1..0 of every FIFO entry
   typedef enum logic [`SNIFF_CMD_W-1:0] {
      CMD_DATA = 2'd0,
      CMD_STAT = 2'd1,
      CMD_TIME = 2'd2,
      CMD_STRM = 2'd3
   } fe_cmd_e;

   // Host register map
   typedef enum logic [`SNIFF_ADDR_W-1:0] {
      REG_ARM                = 6'd1,
      REG_TIMESTAMPS_DISABLE = 6'd2,
      REG_PATTERN            = 6'd3,
      REG_PATTERN_MASK       = 6'd4,
      REG_PATTERN_ACTION     = 6'd5,
      REG_PATTERN_BYTES      = 6'd6,
      REG_CAPTURE_LEN        = 6'd7,
      REG_TRIGGER_DELAY      = 6'd8,
      REG_TRIGGER_WIDTH      = 6'd9,
      REG_SNIFF_FIFO_STAT    = 6'd10,
      REG_SNIFF_FIFO_RD      = 6'd11
   } reg_addr_e;

   typedef logic [`SNIFF_ENTRY_W-1:0] fifo_entry_t;

   // Status byte seen by the host, MSB first
   typedef struct packed {
      logic full_threshold;
      logic overflow_blocked;
      logic full;
      logic empty_threshold;
      logic empty;
   } fifo_status_t;

endpackage

// ==== sniff_defines.svh ====
`ifndef SNIFF_DEFINES_SVH
`define SNIFF_DEFINES_SVH

//////////////////////////////
// Register and bus widths
//////////////////////////////
`define SNIFF_PATTERN_BYTES 8
`define SNIFF_TRIG_DELAY_W 20
`define SNIFF_TRIG_WIDTH_W 16
`define SNIFF_CAPLEN_W 16
`define SNIFF_BYTECNT_W 7
`define SNIFF_ADDR_W 6

//////////////////////////////
// Capture FIFO entry layout
//////////////////////////////
`define SNIFF_TIME_W 16
`define SNIFF_SHORTTIME_W 3
`define SNIFF_STAT_W 5
`define SNIFF_ENTRY_W 18
`define SNIFF_CMD_W 2
`define SNIFF_DATA_W 8
`define SNIFF_CMD_START 0
`define SNIFF_STIME_START 2
`define SNIFF_DATA_START 5
`define SNIFF_STATUS_START 13
`define SNIFF_FTIME_START 2

// FIFO sizing and flag levels
`define SNIFF_FIFO_DEPTH 32
`define SNIFF_FULL_THRESH 28
`define SNIFF_EMPTY_THRESH 4
`define SNIFF_EMPTY_MARKER 8'h01

`endif
